// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the rvseed testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module rvseed_tb -f rvseed.f -o rvseed_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/rvseed_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
	echo "result: pass"
	exit 0
else
	echo "result: fail"
	exit 1
fi

// ==== rvseed.f ====
rvseed_pkg.sv
rvseed_alu.sv
rvseed_ex_mem_regs.sv
rvseed_lsu.sv
rvseed_ex_mem_top.sv
rvseed_tb.sv

// ==== rvseed_alu.sv ====
`timescale 1ns/10ps

module rvseed_alu (
	input  rvseed_pkg::ex_req_t ex_req_i,
	output rvseed_pkg::ex_mem_t ex_mem_o
);

	logic [rvseed_pkg::XLEN-1:0] src1;
	logic [rvseed_pkg::XLEN-1:0] src2;
	logic [5:0]                  shamt;
	logic [rvseed_pkg::XLEN-1:0] alu_val;
	logic [rvseed_pkg::XLEN-1:0] imm_sext;
	logic [rvseed_pkg::XLEN-1:0] eff_addr;
	logic [7:0]                  size_mask;
	logic                        is_mem;

	assign src1  = ex_req_i.src1;
	assign src2  = ex_req_i.src2;
	assign shamt = src2[5:0];   // rv64 shifts use 6 bits

	assign imm_sext = {{(rvseed_pkg::XLEN-32){ex_req_i.imm[31]}}, ex_req_i.imm};
	assign eff_addr = src1 + imm_sext;
	assign is_mem   = ex_req_i.is_load | ex_req_i.is_store;

	always_comb begin
		case (ex_req_i.alu_op)
			rvseed_pkg::ADD:  alu_val = src1 + src2;
			rvseed_pkg::SUB:  alu_val = src1 - src2;
			rvseed_pkg::AND:  alu_val = src1 & src2;
			rvseed_pkg::OR:   alu_val = src1 | src2;
			rvseed_pkg::XOR:  alu_val = src1 ^ src2;
			rvseed_pkg::SLL:  alu_val = src1 << shamt;
			rvseed_pkg::SRL:  alu_val = src1 >> shamt;
			rvseed_pkg::SRA:  alu_val = $signed(src1) >>> shamt;
			rvseed_pkg::SLT: begin
				alu_val = '0;
				alu_val[0] = $signed(src1) < $signed(src2);
			end
			rvseed_pkg::SLTU: begin
				alu_val = '0;
				alu_val[0] = src1 < src2;
			end
			default:          alu_val = '0;
		endcase
	end

	// lanes touched before alignment
	always_comb begin
		case (ex_req_i.size)
			rvseed_pkg::BYTE:  size_mask = 8'b0000_0001;
			rvseed_pkg::HALF:  size_mask = 8'b0000_0011;
			rvseed_pkg::WORD:  size_mask = 8'b0000_1111;
			rvseed_pkg::DWORD: size_mask = 8'b1111_1111;
			default:           size_mask = 8'b0000_0000;
		endcase
	end

	always_comb begin
		ex_mem_o.valid         = ex_req_i.valid;
		ex_mem_o.alu_res       = is_mem ? eff_addr : alu_val;
		ex_mem_o.store_data    = src2 << {eff_addr[2:0], 3'b000};
		ex_mem_o.wmask         = ex_req_i.is_store ? size_mask << eff_addr[2:0] : 8'h00;
		ex_mem_o.is_load       = ex_req_i.is_load;
		ex_mem_o.is_store      = ex_req_i.is_store;
		ex_mem_o.size          = ex_req_i.size;
		ex_mem_o.load_unsigned = ex_req_i.load_unsigned;
		ex_mem_o.byte_off      = eff_addr[2:0];   // load realignment in mem stage
		ex_mem_o.reg_wen       = ex_req_i.reg_wen;
		ex_mem_o.reg_waddr     = ex_req_i.reg_waddr;
		ex_mem_o.ebreak        = ex_req_i.ebreak;
		ex_mem_o.next_pc       = ex_req_i.next_pc;
	end

	// decode must never mark an instruction as both load and store
	always_comb begin
		if (ex_req_i.valid) begin
			assert (!(ex_req_i.is_load && ex_req_i.is_store))
				else $error("rvseed_alu: load and store both set");
		end
	end

endmodule

// ==== rvseed_ex_mem_regs.sv ====
`timescale 1ns/10ps

module rvseed_ex_mem_regs (
	input  logic                clk,
	input  logic                rst_n,
	input  rvseed_pkg::ex_mem_t ex_mem_i,
	output rvseed_pkg::ex_mem_t ex_mem_o
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem_o         <= '0;                      // bubble
			ex_mem_o.next_pc <= rvseed_pkg::RESET_PC;
		end else begin
			ex_mem_o <= ex_mem_i;   // no stall, capture every cycle
		end
	end

	// a store leaving execute always touches at least one byte
	a_store_has_mask: assert property (
		@(posedge clk) disable iff (!rst_n)
		(ex_mem_o.valid && ex_mem_o.is_store) |-> (ex_mem_o.wmask != 8'h00)
	) else $error("rvseed_ex_mem_regs: valid store with empty wmask");

endmodule

// ==== rvseed_ex_mem_top.sv ====
`timescale 1ns/10ps

module rvseed_ex_mem_top #(
	parameter int DMEM_WORDS = 64
) (
	input  logic                clk,
	input  logic                rst_n,
	input  rvseed_pkg::ex_req_t ex_req_i,
	output rvseed_pkg::wb_t     wb_o,
	output logic                halt_o
);

	localparam int DMEM_AW = $clog2(DMEM_WORDS);   // word index width

	rvseed_pkg::ex_mem_t ex_mem_comb;   // execute result, same cycle
	rvseed_pkg::ex_mem_t ex_mem_q;      // memory stage input

	// execute
	rvseed_alu u_alu (
		.ex_req_i (ex_req_i),
		.ex_mem_o (ex_mem_comb)
	);

	rvseed_ex_mem_regs u_ex_mem_regs (
		.clk      (clk),
		.rst_n    (rst_n),
		.ex_mem_i (ex_mem_comb),
		.ex_mem_o (ex_mem_q)
	);

	// memory and write-back register
	rvseed_lsu #(
		.DMEM_WORDS (DMEM_WORDS),
		.DMEM_AW    (DMEM_AW)
	) u_lsu (
		.clk      (clk),
		.rst_n    (rst_n),
		.ex_mem_i (ex_mem_q),
		.wb_o     (wb_o),
		.halt_o   (halt_o)
	);

endmodule

// ==== rvseed_lsu.sv ====
`timescale 1ns/10ps

module rvseed_lsu #(
	parameter int DMEM_WORDS = 64,
	parameter int DMEM_AW    = $clog2(DMEM_WORDS)
) (
	input  logic                clk,
	input  logic                rst_n,
	input  rvseed_pkg::ex_mem_t ex_mem_i,
	output rvseed_pkg::wb_t     wb_o,
	output logic                halt_o
);

	logic [rvseed_pkg::XLEN-1:0] dmem [DMEM_WORDS];

	logic [DMEM_AW-1:0]          word_idx;
	logic [rvseed_pkg::XLEN-1:0] rd_word;
	logic [rvseed_pkg::XLEN-1:0] ld_shift;
	logic [rvseed_pkg::XLEN-1:0] ld_val;
	logic                        ld_sign;
	logic                        misaligned;
	logic                        do_store;

	// address wraps modulo the memory depth
	assign word_idx = ex_mem_i.alu_res[DMEM_AW+2:3];
	assign rd_word  = dmem[word_idx];
	assign do_store = ex_mem_i.valid & ex_mem_i.is_store;

	always_ff @(posedge clk) begin
		if (do_store) begin
			for (int b = 0; b < 8; b++) begin
				if (ex_mem_i.wmask[b])
					dmem[word_idx][b*8 +: 8] <= ex_mem_i.store_data[b*8 +: 8];
			end
		end
	end

	// bring the addressed bytes down to bit 0, then extend
	always_comb begin
		ld_shift = rd_word >> {ex_mem_i.byte_off, 3'b000};
		case (ex_mem_i.size)
			rvseed_pkg::BYTE:  ld_sign = ld_shift[7];
			rvseed_pkg::HALF:  ld_sign = ld_shift[15];
			rvseed_pkg::WORD:  ld_sign = ld_shift[31];
			default:           ld_sign = ld_shift[63];
		endcase
		ld_sign = ld_sign & ~ex_mem_i.load_unsigned;
		case (ex_mem_i.size)
			rvseed_pkg::BYTE:  ld_val = {{56{ld_sign}}, ld_shift[7:0]};
			rvseed_pkg::HALF:  ld_val = {{48{ld_sign}}, ld_shift[15:0]};
			rvseed_pkg::WORD:  ld_val = {{32{ld_sign}}, ld_shift[31:0]};
			default:           ld_val = ld_shift;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_o         <= '0;
			wb_o.next_pc <= rvseed_pkg::RESET_PC;
			halt_o       <= 1'b0;
		end else begin
			wb_o.valid     <= ex_mem_i.valid;
			wb_o.reg_wen   <= ex_mem_i.valid & ex_mem_i.reg_wen;
			wb_o.reg_waddr <= ex_mem_i.reg_waddr;
			wb_o.wdata     <= ex_mem_i.is_load ? ld_val : ex_mem_i.alu_res;
			wb_o.ebreak    <= ex_mem_i.valid & ex_mem_i.ebreak;
			wb_o.next_pc   <= ex_mem_i.next_pc;
			if (ex_mem_i.valid && ex_mem_i.ebreak)
				halt_o <= 1'b1;   // sticky until reset
		end
	end

	always_comb begin
		case (ex_mem_i.size)
			rvseed_pkg::BYTE:  misaligned = 1'b0;
			rvseed_pkg::HALF:  misaligned = ex_mem_i.byte_off[0];
			rvseed_pkg::WORD:  misaligned = |ex_mem_i.byte_off[1:0];
			default:           misaligned = |ex_mem_i.byte_off;
		endcase
	end

	// effective address comes from execute, alignment is checked here
	a_mem_aligned: assert property (
		@(posedge clk) disable iff (!rst_n)
		(ex_mem_i.valid && (ex_mem_i.is_load || ex_mem_i.is_store)) |-> !misaligned
	) else $error("rvseed_lsu: misaligned access at %h", ex_mem_i.alu_res);

endmodule

// ==== rvseed_pkg.sv ====
package rvseed_pkg;

	localparam int XLEN           = 64;
	localparam int REG_ADDR_WIDTH = 5;

	localparam logic [XLEN-1:0] RESET_PC = 64'h8000_0000;

	typedef enum logic [3:0] {
		ADD  = 4'd0,
		SUB  = 4'd1,
		AND  = 4'd2,
		OR   = 4'd3,
		XOR  = 4'd4,
		SLL  = 4'd5,
		SRL  = 4'd6,
		SRA  = 4'd7,
		SLT  = 4'd8,
		SLTU = 4'd9
	} alu_op_e;

	// access size, log2 of the byte count
	typedef enum logic [1:0] {
		BYTE  = 2'd0,
		HALF  = 2'd1,
		WORD  = 2'd2,
		DWORD = 2'd3
	} mem_size_e;

	// decoded instruction entering execute
	typedef struct packed {
		logic                      valid;
		alu_op_e                   alu_op;
		logic [XLEN-1:0]           src1;
		logic [XLEN-1:0]           src2;
		logic [31:0]               imm;          // memory offset
		logic                      is_load;
		logic                      is_store;
		mem_size_e                 size;
		logic                      load_unsigned;
		logic                      reg_wen;
		logic [REG_ADDR_WIDTH-1:0] reg_waddr;
		logic                      ebreak;
		logic [XLEN-1:0]           next_pc;
	} ex_req_t;

	// what the EX/MEM register carries
	typedef struct packed {
		logic                      valid;
		logic [XLEN-1:0]           alu_res;      // result or effective address
		logic [XLEN-1:0]           store_data;   // already in its byte lane
		logic [7:0]                wmask;
		logic                      is_load;
		logic                      is_store;
		mem_size_e                 size;
		logic                      load_unsigned;
		logic [2:0]                byte_off;
		logic                      reg_wen;
		logic [REG_ADDR_WIDTH-1:0] reg_waddr;
		logic                      ebreak;
		logic [XLEN-1:0]           next_pc;
	} ex_mem_t;

	typedef struct packed {
		logic                      valid;
		logic                      reg_wen;
		logic [REG_ADDR_WIDTH-1:0] reg_waddr;
		logic [XLEN-1:0]           wdata;
		logic                      ebreak;
		logic [XLEN-1:0]           next_pc;
	} wb_t;

endpackage

// ==== rvseed_tb.sv ====
`timescale 1ns/10ps

module rvseed_tb;

	localparam int DMEM_WORDS = 64;
	localparam int N_RAND     = 200;
	localparam int SMEM_BYTES = DMEM_WORDS * 8;
	localparam int SMEM_AW    = $clog2(SMEM_BYTES);

	logic                clk;
	logic                rst_n;
	rvseed_pkg::ex_req_t ex_req_i;
	rvseed_pkg::wb_t     wb_o;
	logic                halt_o;

	logic [7:0]  smem [SMEM_BYTES];   // byte wide shadow of the data memory
	logic [31:0] rng;
	logic [63:0] pc_ctr;
	logic        halt_exp;
	int          tbl_len;

	// stimulus table with its expected records
	rvseed_pkg::ex_req_t tbl_req [$];
	rvseed_pkg::wb_t     tbl_exp [$];
	string               tbl_name [$];

	rvseed_pkg::wb_t pend_exp [$];   // predictions still in the pipe
	string           pend_name [$];

	rvseed_ex_mem_top #(
		.DMEM_WORDS (DMEM_WORDS)
	) dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.ex_req_i (ex_req_i),
		.wb_o     (wb_o),
		.halt_o   (halt_o)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [63:0] alu_model(input rvseed_pkg::alu_op_e op,
		input logic [63:0] a, input logic [63:0] b);
		logic [5:0] sh;
		sh = b[5:0];
		case (op)
			rvseed_pkg::ADD:  return a + b;
			rvseed_pkg::SUB:  return a + ~b + 64'd1;
			rvseed_pkg::AND:  return a & b;
			rvseed_pkg::OR:   return a | b;
			rvseed_pkg::XOR:  return a ^ b;
			rvseed_pkg::SLL:  return a << sh;
			rvseed_pkg::SRL:  return a >> sh;
			rvseed_pkg::SRA:  return (a >> sh) | (a[63] ? ~({64{1'b1}} >> sh) : 64'd0);
			rvseed_pkg::SLT:  return (a[63] != b[63]) ? {63'd0, a[63]} : {63'd0, a < b};
			rvseed_pkg::SLTU: return {63'd0, a < b};
			default:          return 64'd0;
		endcase
	endfunction

	// gather little endian from the shadow and extend
	function automatic logic [63:0] load_model(input logic [63:0] addr,
		input rvseed_pkg::mem_size_e size, input logic uns);
		logic [63:0] v;
		int          n;
		n = 1 << size;
		v = '0;
		for (int i = 0; i < 8; i++) begin
			if (i < n)
				v[i*8 +: 8] = smem[SMEM_AW'(addr + 64'(i))];
			else if (!uns && v[n*8-1])
				v[i*8 +: 8] = 8'hff;
		end
		return v;
	endfunction

	// predicts the record and applies a valid store to the shadow
	function automatic rvseed_pkg::wb_t predict(input rvseed_pkg::ex_req_t r);
		rvseed_pkg::wb_t w;
		logic [63:0]     addr;
		int              n;
		addr        = r.src1 + {{32{r.imm[31]}}, r.imm};
		n           = 1 << r.size;
		w.valid     = r.valid;
		w.reg_wen   = r.valid & r.reg_wen;
		w.reg_waddr = r.reg_waddr;
		w.ebreak    = r.valid & r.ebreak;
		w.next_pc   = r.next_pc;
		if (r.is_load)
			w.wdata = load_model(addr, r.size, r.load_unsigned);
		else if (r.is_store)
			w.wdata = addr;
		else
			w.wdata = alu_model(r.alu_op, r.src1, r.src2);
		if (r.valid && r.is_store) begin
			for (int i = 0; i < n; i++)
				smem[SMEM_AW'(addr + 64'(i))] = r.src2[i*8 +: 8];
		end
		return w;
	endfunction

	function automatic rvseed_pkg::ex_req_t alu_req(input rvseed_pkg::alu_op_e op,
		input logic [63:0] a, input logic [63:0] b, input logic [4:0] rd);
		rvseed_pkg::ex_req_t r;
		r           = '0;
		r.valid     = 1'b1;
		r.alu_op    = op;
		r.src1      = a;
		r.src2      = b;
		r.reg_wen   = 1'b1;
		r.reg_waddr = rd;
		return r;
	endfunction

	function automatic rvseed_pkg::ex_req_t mem_req(input logic st,
		input rvseed_pkg::mem_size_e size, input logic uns, input logic [63:0] base,
		input logic [31:0] off, input logic [63:0] data, input logic [4:0] rd);
		rvseed_pkg::ex_req_t r;
		r               = '0;
		r.valid         = 1'b1;
		r.is_store      = st;
		r.is_load       = !st;
		r.size          = size;
		r.load_unsigned = uns;
		r.src1          = base;
		r.imm           = off;
		r.src2          = data;
		r.reg_wen       = !st;   // loads write a register
		r.reg_waddr     = rd;
		return r;
	endfunction

	task automatic add_entry(input string name, input rvseed_pkg::ex_req_t r);
		r.next_pc = pc_ctr;
		pc_ctr += 64'd4;
		tbl_req.push_back(r);
		tbl_exp.push_back(predict(r));
		tbl_name.push_back(name);
	endtask

	task automatic report_failure(input string why);
		$display("SOME TESTS FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic check_wb(input string name, input rvseed_pkg::wb_t exp,
		input rvseed_pkg::wb_t act, input rvseed_pkg::wb_t care);
		if ((act & care) !== (exp & care)) begin
			$display("** Error: %s: wb expected %h, actual %h", name, exp & care, act & care);
			report_failure("write-back record mismatch");
		end
	endtask

	task automatic check_halt(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("** Error: %s: halt expected %b, actual %b", name, exp, act);
			report_failure("halt level mismatch");
		end
	endtask

	// check the record issued two cycles ago and drive the next request
	task automatic step(input string name, input rvseed_pkg::ex_req_t r,
		input rvseed_pkg::wb_t e);
		rvseed_pkg::wb_t care;
		rvseed_pkg::wb_t got;
		string           got_name;
		@(negedge clk);
		if (pend_exp.size() == 2) begin
			got      = pend_exp.pop_front();
			got_name = pend_name.pop_front();
			care     = '1;
			if (!got.valid) begin
				care         = '0;   // only the flags matter for a bubble
				care.valid   = 1'b1;
				care.reg_wen = 1'b1;
				care.ebreak  = 1'b1;
			end
			if (got.ebreak)
				halt_exp = 1'b1;
			check_wb(got_name, got, wb_o, care);
			check_halt(got_name, halt_exp, halt_o);
		end
		ex_req_i = r;
		pend_exp.push_back(e);
		pend_name.push_back(name);
	endtask

	task automatic build_table();
		rvseed_pkg::ex_req_t r;
		rvseed_pkg::mem_size_e sz_e;
		logic [63:0]         data;
		add_entry("add", alu_req(rvseed_pkg::ADD, 64'd5, 64'd7, 5'd1));
		add_entry("add_wrap", alu_req(rvseed_pkg::ADD, 64'hffff_ffff_ffff_ffff, 64'd1, 5'd2));
		add_entry("sub_neg", alu_req(rvseed_pkg::SUB, 64'd3, 64'd5, 5'd3));
		add_entry("and", alu_req(rvseed_pkg::AND, 64'hf0f0_1234_ffff_0000,
			64'h0ff0_ffff_00ff_ff00, 5'd4));
		add_entry("or", alu_req(rvseed_pkg::OR, 64'hf000_0000_0000_000f,
			64'h0f00_0000_0000_00f0, 5'd5));
		add_entry("xor", alu_req(rvseed_pkg::XOR, 64'haaaa_5555_aaaa_5555,
			64'hffff_ffff_0000_0000, 5'd6));
		add_entry("bubble_0", '0);
		add_entry("sll_0", alu_req(rvseed_pkg::SLL, 64'hdead_beef_0123_4567, 64'h40, 5'd7));
		add_entry("sll_63", alu_req(rvseed_pkg::SLL, 64'd3, 64'd63, 5'd8));
		add_entry("srl_63", alu_req(rvseed_pkg::SRL, 64'h8000_0000_0000_0000, 64'hff, 5'd9));
		add_entry("sra_neg", alu_req(rvseed_pkg::SRA, 64'hf000_0000_0000_0010, 64'd4, 5'd10));
		add_entry("sra_neg_63", alu_req(rvseed_pkg::SRA, 64'h8000_0000_0000_0000, 64'd63, 5'd11));
		add_entry("sra_0", alu_req(rvseed_pkg::SRA, 64'h8000_0000_0000_0001, 64'd0, 5'd12));
		add_entry("slt_neg", alu_req(rvseed_pkg::SLT, 64'hffff_ffff_ffff_ffff, 64'd1, 5'd13));
		add_entry("sltu_neg", alu_req(rvseed_pkg::SLTU, 64'hffff_ffff_ffff_ffff, 64'd1, 5'd14));
		add_entry("slt_pos", alu_req(rvseed_pkg::SLT, 64'd1, 64'hffff_ffff_ffff_ffff, 5'd15));
		add_entry("sltu_small", alu_req(rvseed_pkg::SLTU, 64'd1, 64'hffff_ffff_ffff_ffff, 5'd16));
		add_entry("slt_eq", alu_req(rvseed_pkg::SLT, 64'd5, 64'd5, 5'd17));
		add_entry("st_init", mem_req(1'b1, rvseed_pkg::DWORD, 1'b0, 64'h100, 32'd0,
			64'h0123_4567_89ab_cdef, 5'd0));
		// bytes fill 0x108, halves 0x110, words 0x118
		for (int sz = 0; sz < 3; sz++) begin
			for (int off = 0; off < 8; off += (1 << sz)) begin
				rng  = xorshift32(rng);
				data = {rng, ~rng};
				sz_e = rvseed_pkg::mem_size_e'(2'(sz));
				add_entry($sformatf("st_%0d_%0d", sz, off), mem_req(1'b1, sz_e, 1'b0,
					64'h100, 32'(8 + 8 * sz + off), data, 5'd0));
			end
		end
		// every load size and sign over 0x100..0x11f via negative offsets from 0x120
		for (int sz = 0; sz < 4; sz++) begin
			for (int uns = 0; uns < 2; uns++) begin
				for (int off = 0; off < 32; off += (1 << sz)) begin
					sz_e = rvseed_pkg::mem_size_e'(2'(sz));
					add_entry($sformatf("ld_%0d_%0d_%0d", sz, uns, off), mem_req(1'b0, sz_e,
						1'(uns), 64'h120, 32'(off - 32), 64'd0, 5'(off)));
				end
			end
		end
		add_entry("b2b_st", mem_req(1'b1, rvseed_pkg::DWORD, 1'b0, 64'h110, 32'd0,
			64'h5a5a_0000_1234_8765, 5'd0));
		add_entry("b2b_ld", mem_req(1'b0, rvseed_pkg::DWORD, 1'b0, 64'h110, 32'd0, 64'd0, 5'd20));
		add_entry("b2b_st_w", mem_req(1'b1, rvseed_pkg::WORD, 1'b0, 64'h118, 32'd4,
			64'h8000_0001, 5'd0));
		add_entry("b2b_ld_w", mem_req(1'b0, rvseed_pkg::WORD, 1'b0, 64'h118, 32'd4, 64'd0, 5'd21));
		add_entry("mix_add", alu_req(rvseed_pkg::ADD, 64'd100, 64'd23, 5'd22));
		add_entry("bubble_1", '0);
		add_entry("bubble_2", '0);
		add_entry("mix_xor", alu_req(rvseed_pkg::XOR, 64'd9, 64'd6, 5'd23));
		add_entry("bubble_3", '0);
		add_entry("pre_halt", alu_req(rvseed_pkg::OR, 64'h10, 64'h1, 5'd24));
		r        = '0;
		r.valid  = 1'b1;
		r.ebreak = 1'b1;
		add_entry("ebreak", r);
		add_entry("post_halt_alu", alu_req(rvseed_pkg::SUB, 64'd50, 64'd8, 5'd25));
		add_entry("post_halt_ld", mem_req(1'b0, rvseed_pkg::HALF, 1'b1, 64'h110, 32'd2,
			64'd0, 5'd26));
	endtask

	initial begin
		rvseed_pkg::ex_req_t r;
		rvseed_pkg::wb_t     care;
		rvseed_pkg::wb_t     exp_rst;
		clk      = 1'b0;
		rst_n    = 1'b0;
		ex_req_i = '0;
		halt_exp = 1'b0;
		rng      = 32'hb2edfc49;
		pc_ctr   = rvseed_pkg::RESET_PC + 64'd4;
		build_table();
		tbl_len = tbl_req.size();
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		care            = '0;
		care.valid      = 1'b1;
		care.reg_wen    = 1'b1;
		care.ebreak     = 1'b1;
		care.next_pc    = '1;
		exp_rst         = '0;
		exp_rst.next_pc = rvseed_pkg::RESET_PC;
		check_wb("reset", exp_rst, wb_o, care);
		check_halt("reset", 1'b0, halt_o);
		for (int i = 0; i < tbl_len; i++)
			step(tbl_name[i], tbl_req[i], tbl_exp[i]);
		for (int i = 0; i < N_RAND; i++) begin
			r = '0;
			rng = xorshift32(rng);
			r.src1[63:32] = rng;
			rng = xorshift32(rng);
			r.src1[31:0] = rng;
			rng = xorshift32(rng);
			r.src2[63:32] = rng;
			rng = xorshift32(rng);
			r.src2[31:0] = rng;
			rng = xorshift32(rng);
			r.valid     = (rng[2:0] != 3'd0);   // about one bubble in eight
			r.alu_op    = rvseed_pkg::alu_op_e'(4'(rng % 10));
			r.reg_wen   = 1'b1;
			r.reg_waddr = rng[12:8];
			r.next_pc   = pc_ctr;
			pc_ctr += 64'd4;
			step($sformatf("rand_%0d", i), r, predict(r));
		end
		step("drain", '0, '0);
		step("drain", '0, '0);
		$display("ALL TESTS PASSED");
		$finish;
	end

	// watchdog
	initial begin
		wait (tbl_len > 0);
		#((tbl_len + N_RAND + 50) * 10);
		$display("watchdog: the run did not finish within %0d cycles", tbl_len + N_RAND + 50);
		report_failure("timeout");
	end

endmodule
